// File: all.f
hw/priv_arch_pkg.sv
hw/priv_pipe_pkg.sv
hw/priv_csr_front.sv
hw/priv_trap_ctrl.sv
hw/priv_csr_rfile.sv
hw/priv_redirect.sv
hw/priv_block.sv
tests/priv_block_tb.sv

// File: hw/priv_arch_pkg.sv
// Architectural definitions of the machine-mode privileged unit.
// Holds CSR addresses, trap cause codes and the mstatus layout.
`default_nettype none

package priv_arch_pkg;

  // CSR address as encoded in the instruction.
  typedef logic [11:0] csr_addr_t;

  // Exception or interrupt code, the low bits of mcause.
  typedef logic [3:0] cause_code_t;

  // Implemented machine CSRs.
  localparam csr_addr_t csr_mstatus  = 12'h300;
  localparam csr_addr_t csr_mie      = 12'h304;
  localparam csr_addr_t csr_mtvec    = 12'h305;
  localparam csr_addr_t csr_mscratch = 12'h340;
  localparam csr_addr_t csr_mepc     = 12'h341;
  localparam csr_addr_t csr_mcause   = 12'h342;
  localparam csr_addr_t csr_mtval    = 12'h343;
  localparam csr_addr_t csr_mip      = 12'h344;
  localparam csr_addr_t csr_minstret = 12'hb02;

  // Synchronous exception codes.
  localparam cause_code_t cause_insn_fault  = 4'd1;
  localparam cause_code_t cause_illegal     = 4'd2;
  localparam cause_code_t cause_breakpoint  = 4'd3;
  localparam cause_code_t cause_load_mal    = 4'd4;
  localparam cause_code_t cause_load_fault  = 4'd5;
  localparam cause_code_t cause_store_mal   = 4'd6;
  localparam cause_code_t cause_store_fault = 4'd7;
  localparam cause_code_t cause_ecall_m     = 4'd11;

  // Interrupt codes, reported with mcause bit 31 set.
  localparam cause_code_t cause_timer_int = 4'd7;
  localparam cause_code_t cause_ext_int   = 4'd11;

  // Enable and pending bit positions in mie and mip.
  localparam int unsigned mie_mtie_bit = 7;
  localparam int unsigned mie_meie_bit = 11;

  // Only the timer and external enables are writable.
  localparam logic [31:0] mie_wmask = 32'h0000_0880;

  // mstatus, machine mode fields only.
  typedef struct packed {
    logic [23:0] rsvd_hi;
    logic        mpie;
    logic [2:0]  rsvd_mid;
    logic        mie;
    logic [2:0]  rsvd_lo;
  } mstatus_bits_t;

  // One CSR data word, viewed raw or as mstatus.
  typedef union packed {
    logic [31:0]   raw;
    mstatus_bits_t status;
  } csr_word_u;

endpackage

`default_nettype wire

// File: hw/priv_block.sv
// Machine-mode privileged unit, top level.
// Connects the CSR front end, trap controller, register file and redirect.
`default_nettype none

module priv_block (
  input  wire logic                       CLK,
  input  wire logic                       rst_n,
  input  wire logic                       csr_req,
  input  wire priv_pipe_pkg::csr_req_t    req,
  output logic                            csr_ack,
  output priv_pipe_pkg::csr_rsp_t         rsp,
  input  wire logic                       exc_valid,
  input  wire priv_pipe_pkg::exc_report_t exc,
  input  wire logic                       mret,
  input  wire logic                       retire,
  input  wire logic                       int_window,
  input  wire logic                       ext_int,
  input  wire logic                       timer_int,
  output logic [31:0]                     priv_pc,
  output logic                            insert_pc
);

  priv_arch_pkg::csr_addr_t     rd_addr;
  priv_pipe_pkg::csr_wr_t       wr;
  priv_pipe_pkg::trap_t         trap;
  priv_arch_pkg::mstatus_bits_t status;
  logic [31:0]                  rdata_raw;
  logic                         addr_valid;
  logic [31:0]                  mie_bits;
  logic [31:0]                  mtvec;
  logic [31:0]                  mepc;

  // CSR handshake and merge.
  priv_csr_front u_front (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .csr_req    (csr_req),
    .req        (req),
    .rdata_raw  (rdata_raw),
    .addr_valid (addr_valid),
    .csr_ack    (csr_ack),
    .rsp        (rsp),
    .wr         (wr),
    .rd_addr    (rd_addr)
  );

  priv_trap_ctrl u_trap (
    .exc_valid  (exc_valid),
    .exc        (exc),
    .mret       (mret),
    .int_window (int_window),
    .ext_int    (ext_int),
    .timer_int  (timer_int),
    .status     (status),
    .mie_bits   (mie_bits),
    .trap       (trap)
  );

  priv_csr_rfile u_rfile (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .rd_addr    (rd_addr),
    .wr         (wr),
    .trap       (trap),
    .mret       (mret),
    .retire     (retire),
    .ext_int    (ext_int),
    .timer_int  (timer_int),
    .rdata_raw  (rdata_raw),
    .addr_valid (addr_valid),
    .status     (status),
    .mie_bits   (mie_bits),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

  // Target PC toward fetch.
  priv_redirect u_redirect (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .trap      (trap),
    .mret      (mret),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .priv_pc   (priv_pc),
    .insert_pc (insert_pc)
  );

endmodule

`default_nettype wire

// File: hw/priv_csr_front.sv
// CSR request front end.
// Runs the four-phase req/ack handshake and merges swap, set and clear
// with the current register value.
`default_nettype none

module priv_csr_front (
  input  wire logic                      CLK,
  input  wire logic                      rst_n,
  input  wire logic                      csr_req,
  input  wire priv_pipe_pkg::csr_req_t   req,
  input  wire logic [31:0]               rdata_raw,
  input  wire logic                      addr_valid,
  output logic                           csr_ack,
  output priv_pipe_pkg::csr_rsp_t        rsp,
  output priv_pipe_pkg::csr_wr_t         wr,
  output priv_arch_pkg::csr_addr_t       rd_addr
);

  typedef enum logic {
    st_idle,
    st_acked
  } state_e;

  state_e                   state_q;
  logic                     start;
  priv_arch_pkg::csr_word_u merged;

  // Access is taken on the first edge req is seen in idle.
  assign start   = csr_req && (state_q == st_idle);
  assign rd_addr = req.addr;

  // Merge rule on the word read from the register file.
  always_comb begin
    merged.raw = rdata_raw;
    case (req.op)
      priv_pipe_pkg::csr_op_swap:  merged.raw = req.wdata;
      priv_pipe_pkg::csr_op_set:   merged.raw = rdata_raw | req.wdata;
      priv_pipe_pkg::csr_op_clear: merged.raw = rdata_raw & ~req.wdata;
      default:                     merged.raw = rdata_raw;
    endcase
  end

  // One-cycle write strobe, dropped for unknown addresses.
  always_comb begin
    wr.en   = start && addr_valid;
    wr.addr = req.addr;
    wr.data = merged;
  end

  // Handshake FSM; ack trails the state by one cycle on both edges.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state_q <= st_idle;
      csr_ack <= 1'b0;
    end else begin
      csr_ack <= (state_q == st_acked);
      case (state_q)
        st_idle:  if (csr_req) state_q <= st_acked;
        st_acked: if (!csr_req) state_q <= st_idle;
        default:  state_q <= st_idle;
      endcase
    end
  end

  // Response captured with the write, held through ack.
  always_ff @(posedge CLK) begin
    if (start) begin
      rsp.rdata       <= addr_valid ? rdata_raw : 32'd0;
      rsp.invalid_csr <= !addr_valid;
    end
  end

  // Ack rises only after two cycles of req.
  a_ack_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(csr_ack) |-> $past(csr_req) && $past(csr_req, 2))
    else $error("csr_ack rose without a held request");

endmodule

`default_nettype wire

// File: hw/priv_csr_rfile.sv
// Machine CSR register file.
// Holds the machine CSRs and applies trap, mret, CSR write and retire
// updates in that order of precedence.
`default_nettype none

module priv_csr_rfile (
  input  wire logic                      CLK,
  input  wire logic                      rst_n,
  input  wire priv_arch_pkg::csr_addr_t  rd_addr,
  input  wire priv_pipe_pkg::csr_wr_t    wr,
  input  wire priv_pipe_pkg::trap_t      trap,
  input  wire logic                      mret,
  input  wire logic                      retire,
  input  wire logic                      ext_int,
  input  wire logic                      timer_int,
  output logic [31:0]                    rdata_raw,
  output logic                           addr_valid,
  output priv_arch_pkg::mstatus_bits_t   status,
  output logic [31:0]                    mie_bits,
  output logic [31:0]                    mtvec,
  output logic [31:0]                    mepc
);

  logic [31:0] mscratch_q;
  logic [31:0] mcause_q;
  logic [31:0] mtval_q;
  logic [31:0] minstret_q;
  logic [31:0] mip_live;

  // Live interrupt levels at bits 11 and 7.
  assign mip_live = {20'd0, ext_int, 3'd0, timer_int, 7'd0};

  // Read decode and address check.
  always_comb begin
    rdata_raw  = 32'd0;
    addr_valid = 1'b1;
    case (rd_addr)
      priv_arch_pkg::csr_mstatus:  rdata_raw = status;
      priv_arch_pkg::csr_mie:      rdata_raw = mie_bits;
      priv_arch_pkg::csr_mip:      rdata_raw = mip_live;
      priv_arch_pkg::csr_mtvec:    rdata_raw = mtvec;
      priv_arch_pkg::csr_mscratch: rdata_raw = mscratch_q;
      priv_arch_pkg::csr_mepc:     rdata_raw = mepc;
      priv_arch_pkg::csr_mcause:   rdata_raw = mcause_q;
      priv_arch_pkg::csr_mtval:    rdata_raw = mtval_q;
      priv_arch_pkg::csr_minstret: rdata_raw = minstret_q;
      default:                     addr_valid = 1'b0;
    endcase
  end

  // Registers with reset.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      status     <= '0;
      mie_bits   <= 32'd0;
      mcause_q   <= 32'd0;
      minstret_q <= 32'd0;
    end else begin
      // Trap pushes the enable stack, mret pops it.
      if (trap.take) begin
        status.mpie <= status.mie;
        status.mie  <= 1'b0;
      end else if (mret) begin
        status.mie  <= status.mpie;
        status.mpie <= 1'b1;
      end else if (wr.en && wr.addr == priv_arch_pkg::csr_mstatus) begin
        status.mie  <= wr.data.status.mie;
        status.mpie <= wr.data.status.mpie;
      end
      if (wr.en && wr.addr == priv_arch_pkg::csr_mie)
        mie_bits <= wr.data.raw & priv_arch_pkg::mie_wmask;
      if (trap.take)
        mcause_q <= {trap.is_intr, 27'd0, trap.cause};
      else if (wr.en && wr.addr == priv_arch_pkg::csr_mcause)
        mcause_q <= wr.data.raw;
      // minstret is read-only here.
      if (retire)
        minstret_q <= minstret_q + 32'd1;
    end
  end

  // Payload registers.
  always_ff @(posedge CLK) begin
    if (wr.en && wr.addr == priv_arch_pkg::csr_mtvec)
      mtvec <= wr.data.raw;
    if (wr.en && wr.addr == priv_arch_pkg::csr_mscratch)
      mscratch_q <= wr.data.raw;
    if (trap.take)
      mepc <= trap.epc;
    else if (wr.en && wr.addr == priv_arch_pkg::csr_mepc)
      mepc <= wr.data.raw;
    if (trap.take)
      mtval_q <= trap.tval;
    else if (wr.en && wr.addr == priv_arch_pkg::csr_mtval)
      mtval_q <= wr.data.raw;
  end

  // CSR write and trap never share an edge.
  a_no_write_on_trap: assert property (@(posedge CLK) disable iff (!rst_n)
    !(wr.en && trap.take))
    else $error("CSR write and trap in the same cycle");

endmodule

`default_nettype wire

// File: hw/priv_pipe_pkg.sv
// Pipeline-facing types of the privileged unit.
// Requests, responses and the internal trap and write records.
`default_nettype none

package priv_pipe_pkg;

  // CSR operation, as decoded from csrrw, csrrs and csrrc.
  typedef enum logic [1:0] {
    csr_op_swap  = 2'b01,
    csr_op_set   = 2'b10,
    csr_op_clear = 2'b11
  } csr_op_e;

  // CSR request, held steady while csr_req is high.
  typedef struct packed {
    csr_op_e                  op;
    priv_arch_pkg::csr_addr_t addr;
    logic [31:0]              wdata;
  } csr_req_t;

  // CSR response, valid while csr_ack is high.
  typedef struct packed {
    logic [31:0] rdata;
    logic        invalid_csr;
  } csr_rsp_t;

  // Fault report of the committing instruction.
  typedef struct packed {
    logic        breakpoint;
    logic        fault_insn;
    logic        illegal_insn;
    logic        env_m;
    logic        mal_l;
    logic        fault_l;
    logic        mal_s;
    logic        fault_s;
    logic [31:0] epc;
    logic [31:0] badaddr;
  } exc_report_t;

  // Trap decision for the register file and the redirect.
  typedef struct packed {
    logic                       take;
    logic                       is_intr;
    priv_arch_pkg::cause_code_t cause;
    logic [31:0]                epc;
    logic [31:0]                tval;
  } trap_t;

  // Merged CSR write toward the register file.
  typedef struct packed {
    logic                     en;
    priv_arch_pkg::csr_addr_t addr;
    priv_arch_pkg::csr_word_u data;
  } csr_wr_t;

endpackage

`default_nettype wire

// File: hw/priv_redirect.sv
// Pipeline redirect control.
// Registers the trap or return target and pulses insert_pc for one
// cycle toward fetch.
`default_nettype none

module priv_redirect (
  input  wire logic                  CLK,
  input  wire logic                  rst_n,
  input  wire priv_pipe_pkg::trap_t  trap,
  input  wire logic                  mret,
  input  wire logic [31:0]           mtvec,
  input  wire logic [31:0]           mepc,
  output logic [31:0]                priv_pc,
  output logic                       insert_pc
);

  // One pulse per trap or mret edge.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      insert_pc <= 1'b0;
    end else begin
      insert_pc <= trap.take || mret;
    end
  end

  // Direct mode only, so the mode bits are masked off.
  always_ff @(posedge CLK) begin
    if (trap.take)
      priv_pc <= {mtvec[31:2], 2'b00};
    else if (mret)
      priv_pc <= mepc;
  end

endmodule

`default_nettype wire

// File: hw/priv_trap_ctrl.sv
// Trap controller.
// Ranks the fault flags, arbitrates the interrupt lines and decides
// whether the committing instruction traps.
`default_nettype none

module priv_trap_ctrl (
  input  wire logic                         exc_valid,
  input  wire priv_pipe_pkg::exc_report_t   exc,
  input  wire logic                         mret,
  input  wire logic                         int_window,
  input  wire logic                         ext_int,
  input  wire logic                         timer_int,
  input  wire priv_arch_pkg::mstatus_bits_t status,
  input  wire logic [31:0]                  mie_bits,
  output priv_pipe_pkg::trap_t              trap
);

  logic                       exc_any;
  logic                       ext_pend;
  logic                       timer_pend;
  logic                       int_take;
  priv_arch_pkg::cause_code_t exc_cause;

  assign exc_any = exc_valid && |{exc.breakpoint, exc.fault_insn, exc.illegal_insn,
                                  exc.env_m, exc.mal_l, exc.fault_l,
                                  exc.mal_s, exc.fault_s};

  // Fixed priority, breakpoint highest.
  always_comb begin
    if (exc.breakpoint)        exc_cause = priv_arch_pkg::cause_breakpoint;
    else if (exc.fault_insn)   exc_cause = priv_arch_pkg::cause_insn_fault;
    else if (exc.illegal_insn) exc_cause = priv_arch_pkg::cause_illegal;
    else if (exc.env_m)        exc_cause = priv_arch_pkg::cause_ecall_m;
    else if (exc.mal_l)        exc_cause = priv_arch_pkg::cause_load_mal;
    else if (exc.fault_l)      exc_cause = priv_arch_pkg::cause_load_fault;
    else if (exc.mal_s)        exc_cause = priv_arch_pkg::cause_store_mal;
    else                       exc_cause = priv_arch_pkg::cause_store_fault;
  end

  // Line high and enabled in mie.
  assign ext_pend   = ext_int && mie_bits[priv_arch_pkg::mie_meie_bit];
  assign timer_pend = timer_int && mie_bits[priv_arch_pkg::mie_mtie_bit];

  // Interrupts wait for a clear pipe and a quiet commit slot.
  assign int_take = int_window && !exc_valid && !mret && status.mie &&
                    (ext_pend || timer_pend);

  always_comb begin
    trap.take    = exc_any || int_take;
    trap.is_intr = int_take;
    trap.epc     = exc.epc;
    if (int_take) begin
      // External ranks above timer.
      trap.cause = ext_pend ? priv_arch_pkg::cause_ext_int
                            : priv_arch_pkg::cause_timer_int;
      trap.tval  = 32'd0;
    end else begin
      trap.cause = exc_cause;
      trap.tval  = exc.badaddr;
    end
  end

  // Pipeline never commits a faulting mret.
  a_no_trap_on_mret: assert #0 (!(trap.take === 1'b1 && mret === 1'b1))
    else $error("trap taken in the same cycle as mret");

endmodule

`default_nettype wire

// File: tests/priv_block_tb.sv
// Directed testbench for the machine-mode privileged unit.
// Checks CSR access, traps, mret, interrupts and minstret against a register model.
`default_nettype none

module priv_block_tb;

  // Watchdog budget is accesses times their cost plus the pulse tests, times four for margin.
  localparam int unsigned access_count    = 60;
  localparam int unsigned access_cost     = 8;
  localparam int unsigned pulse_cycles    = 20;
  localparam int unsigned watchdog_cycles = 4 * (access_count * access_cost + pulse_cycles);
  localparam int unsigned ack_timeout     = 4;

  logic                       CLK;
  logic                       rst_n;
  logic                       csr_req;
  priv_pipe_pkg::csr_req_t    req;
  logic                       csr_ack;
  priv_pipe_pkg::csr_rsp_t    rsp;
  logic                       exc_valid;
  priv_pipe_pkg::exc_report_t exc;
  logic                       mret;
  logic                       retire;
  logic                       int_window;
  logic                       ext_int;
  logic                       timer_int;
  logic [31:0]                priv_pc;
  logic                       insert_pc;

  // Expected register state.
  logic [31:0] m_mstatus;
  logic [31:0] m_mie;
  logic [31:0] m_mtvec;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mtval;
  logic [31:0] m_minstret;
  logic [31:0] rng;

  priv_block u_dut (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .csr_req    (csr_req),
    .req        (req),
    .csr_ack    (csr_ack),
    .rsp        (rsp),
    .exc_valid  (exc_valid),
    .exc        (exc),
    .mret       (mret),
    .retire     (retire),
    .int_window (int_window),
    .ext_int    (ext_int),
    .timer_int  (timer_int),
    .priv_pc    (priv_pc),
    .insert_pc  (insert_pc)
  );

  always #2 CLK = ~CLK;

  task automatic end_failed();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic fail_with(input string why);
    $display("Error: %s", why);
    end_failed();
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift(rng);
    v = rng;
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      end_failed();
    end
  endtask

  task automatic check_rsp(input priv_pipe_pkg::csr_rsp_t got,
                           input priv_pipe_pkg::csr_rsp_t exp);
    if (got !== exp) begin
      $display("** Error: rsp rdata = %h invalid_csr = %h, expected %h %h",
               got.rdata, got.invalid_csr, exp.rdata, exp.invalid_csr);
      end_failed();
    end
  endtask

  function automatic logic is_implemented(input priv_arch_pkg::csr_addr_t addr);
    case (addr)
      priv_arch_pkg::csr_mstatus, priv_arch_pkg::csr_mie, priv_arch_pkg::csr_mip,
      priv_arch_pkg::csr_mtvec, priv_arch_pkg::csr_mscratch, priv_arch_pkg::csr_mepc,
      priv_arch_pkg::csr_mcause, priv_arch_pkg::csr_mtval,
      priv_arch_pkg::csr_minstret: return 1'b1;
      default:                     return 1'b0;
    endcase
  endfunction

  // Unknown addresses and mip read zero; lines are low during accesses.
  function automatic logic [31:0] model_read(input priv_arch_pkg::csr_addr_t addr);
    case (addr)
      priv_arch_pkg::csr_mstatus:  return m_mstatus;
      priv_arch_pkg::csr_mie:      return m_mie;
      priv_arch_pkg::csr_mtvec:    return m_mtvec;
      priv_arch_pkg::csr_mscratch: return m_mscratch;
      priv_arch_pkg::csr_mepc:     return m_mepc;
      priv_arch_pkg::csr_mcause:   return m_mcause;
      priv_arch_pkg::csr_mtval:    return m_mtval;
      priv_arch_pkg::csr_minstret: return m_minstret;
      default:                     return 32'd0;
    endcase
  endfunction

  // Only mie and mpie live in mstatus, only meie and mtie in mie.
  task automatic model_write(input priv_arch_pkg::csr_addr_t addr, input logic [31:0] v);
    case (addr)
      priv_arch_pkg::csr_mstatus:  m_mstatus = v & 32'h0000_0088;
      priv_arch_pkg::csr_mie:      m_mie = v & 32'h0000_0880;
      priv_arch_pkg::csr_mtvec:    m_mtvec = v;
      priv_arch_pkg::csr_mscratch: m_mscratch = v;
      priv_arch_pkg::csr_mepc:     m_mepc = v;
      priv_arch_pkg::csr_mcause:   m_mcause = v;
      priv_arch_pkg::csr_mtval:    m_mtval = v;
      default:                     ;
    endcase
  endtask

  function automatic logic [31:0] merge(input priv_pipe_pkg::csr_op_e op,
                                        input logic [31:0] old, input logic [31:0] wd);
    case (op)
      priv_pipe_pkg::csr_op_swap: return wd;
      priv_pipe_pkg::csr_op_set:  return old | wd;
      default:                    return old & ~wd;
    endcase
  endfunction

  // Trap pushes mie into mpie; mret pops it and sets mpie.
  task automatic model_trap(input logic [31:0] cause, input logic [31:0] epc,
                            input logic [31:0] tval);
    m_mepc       = epc;
    m_mcause     = cause;
    m_mtval      = tval;
    m_mstatus[7] = m_mstatus[3];
    m_mstatus[3] = 1'b0;
  endtask

  task automatic model_mret();
    m_mstatus[3] = m_mstatus[7];
    m_mstatus[7] = 1'b1;
  endtask

  // Full four-phase cycle that starts and ends on a falling edge with ack low.
  task automatic csr_access(input priv_pipe_pkg::csr_op_e op,
                            input priv_arch_pkg::csr_addr_t addr,
                            input logic [31:0] wdata,
                            output priv_pipe_pkg::csr_rsp_t got);
    int unsigned waited;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    csr_req   = 1'b1;
    waited    = 0;
    while (!csr_ack) begin
      @(negedge CLK);
      waited++;
      if (waited > ack_timeout)
        fail_with("csr_ack did not rise after csr_req");
    end
    got     = rsp;
    csr_req = 1'b0;
    waited  = 0;
    while (csr_ack) begin
      @(negedge CLK);
      waited++;
      if (waited > ack_timeout)
        fail_with("csr_ack did not fall after csr_req dropped");
    end
  endtask

  // Access, compare with the model, then apply the merge to the model.
  task automatic access_check(input priv_pipe_pkg::csr_op_e op,
                              input priv_arch_pkg::csr_addr_t addr,
                              input logic [31:0] wdata);
    priv_pipe_pkg::csr_rsp_t got;
    priv_pipe_pkg::csr_rsp_t exp;
    logic [31:0]             old;
    old             = model_read(addr);
    exp.rdata       = old;
    exp.invalid_csr = !is_implemented(addr);
    csr_access(op, addr, wdata, got);
    check_rsp(got, exp);
    if (is_implemented(addr))
      model_write(addr, merge(op, old, wdata));
  endtask

  task automatic raise_exc(input priv_pipe_pkg::exc_report_t rep);
    exc       = rep;
    exc_valid = 1'b1;
    @(negedge CLK);
    exc_valid = 1'b0;
    exc       = '0;
  endtask

  task automatic do_mret();
    mret = 1'b1;
    @(negedge CLK);
    mret = 1'b0;
  endtask

  task automatic retire_n(input int unsigned n);
    repeat (n) begin
      retire = 1'b1;
      @(negedge CLK);
      retire = 1'b0;
      @(negedge CLK);
    end
  endtask

  // One cycle of open window. The epc rides on the report with exc_valid low.
  task automatic raise_irq(input logic ext, input logic timer, input logic [31:0] epc);
    exc.epc    = epc;
    ext_int    = ext;
    timer_int  = timer;
    int_window = 1'b1;
    @(negedge CLK);
    ext_int    = 1'b0;
    timer_int  = 1'b0;
    int_window = 1'b0;
    exc        = '0;
  endtask

  task automatic check_redirect(input logic [31:0] exp_pc);
    int unsigned waited;
    waited = 0;
    while (!insert_pc) begin
      if (waited == 2)
        fail_with("insert_pc did not pulse within 2 cycles");
      @(negedge CLK);
      waited++;
    end
    check_word("priv_pc", priv_pc, exp_pc);
    @(negedge CLK);
    if (insert_pc)
      fail_with("insert_pc stayed high for more than one cycle");
  endtask

  task automatic expect_no_redirect();
    repeat (2) begin
      if (insert_pc)
        fail_with("insert_pc pulsed although the interrupt is disabled");
      @(negedge CLK);
    end
  endtask

  task automatic test_merge();
    priv_pipe_pkg::csr_rsp_t got;
    logic [31:0]             wd;
    // Prime the two registers that have no reset value.
    next_rand(wd);
    csr_access(priv_pipe_pkg::csr_op_swap, priv_arch_pkg::csr_mscratch, wd, got);
    m_mscratch = wd;
    next_rand(wd);
    csr_access(priv_pipe_pkg::csr_op_swap, priv_arch_pkg::csr_mtvec, wd, got);
    m_mtvec = wd;
    repeat (4) begin
      next_rand(wd);
      access_check(priv_pipe_pkg::csr_op_swap, priv_arch_pkg::csr_mscratch, wd);
      next_rand(wd);
      access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mscratch, wd);
      next_rand(wd);
      access_check(priv_pipe_pkg::csr_op_clear, priv_arch_pkg::csr_mscratch, wd);
      next_rand(wd);
      access_check(priv_pipe_pkg::csr_op_swap, priv_arch_pkg::csr_mtvec, wd);
      next_rand(wd);
      access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mtvec, wd);
      next_rand(wd);
      access_check(priv_pipe_pkg::csr_op_clear, priv_arch_pkg::csr_mtvec, wd);
    end
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mscratch, 32'd0);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mtvec, 32'd0);
  endtask

  task automatic test_invalid();
    logic [31:0] wd;
    next_rand(wd);
    access_check(priv_pipe_pkg::csr_op_swap, 12'h7c0, wd);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mscratch, 32'd0);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mtvec, 32'd0);
    // The swap must leave the read-only minstret at zero.
    next_rand(wd);
    access_check(priv_pipe_pkg::csr_op_swap, priv_arch_pkg::csr_minstret, wd);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_minstret, 32'd0);
  endtask

  task automatic read_trap_csrs();
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mcause, 32'd0);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mepc, 32'd0);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mtval, 32'd0);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mstatus, 32'd0);
  endtask

  task automatic test_exception();
    priv_pipe_pkg::exc_report_t rep;
    // Mode bits of mtvec set so the trap target must mask them.
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mtvec, 32'h3);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mstatus, 32'h8);
    rep              = '0;
    rep.illegal_insn = 1'b1;
    rep.env_m        = 1'b1;
    rep.fault_l      = 1'b1;
    rep.mal_s        = 1'b1;
    next_rand(rep.epc);
    next_rand(rep.badaddr);
    raise_exc(rep);
    // Illegal instruction outranks ecall and the data faults and gives code 2.
    model_trap(32'd2, rep.epc, rep.badaddr);
    check_redirect({m_mtvec[31:2], 2'b00});
    read_trap_csrs();
  endtask

  task automatic test_mret();
    do_mret();
    model_mret();
    check_redirect(m_mepc);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mstatus, 32'd0);
    // Second mret from a cleared mpie shows that mret sets mpie.
    access_check(priv_pipe_pkg::csr_op_clear, priv_arch_pkg::csr_mstatus, 32'h88);
    do_mret();
    model_mret();
    check_redirect(m_mepc);
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mstatus, 32'd0);
  endtask

  task automatic test_interrupts();
    logic [31:0] epc;
    access_check(priv_pipe_pkg::csr_op_clear, priv_arch_pkg::csr_mstatus, 32'h8);
    access_check(priv_pipe_pkg::csr_op_swap, priv_arch_pkg::csr_mie, 32'h880);
    next_rand(epc);
    raise_irq(1'b1, 1'b0, epc);
    expect_no_redirect();
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mcause, 32'd0);
    // Global enable on and the external line alone.
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mstatus, 32'h8);
    next_rand(epc);
    raise_irq(1'b1, 1'b0, epc);
    model_trap(32'h8000_000b, epc, 32'd0);
    check_redirect({m_mtvec[31:2], 2'b00});
    read_trap_csrs();
    do_mret();
    model_mret();
    check_redirect(m_mepc);
    // Timer alone and then both lines.
    next_rand(epc);
    raise_irq(1'b0, 1'b1, epc);
    model_trap(32'h8000_0007, epc, 32'd0);
    check_redirect({m_mtvec[31:2], 2'b00});
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_mcause, 32'd0);
    do_mret();
    model_mret();
    check_redirect(m_mepc);
    next_rand(epc);
    raise_irq(1'b1, 1'b1, epc);
    model_trap(32'h8000_000b, epc, 32'd0);
    check_redirect({m_mtvec[31:2], 2'b00});
    read_trap_csrs();
  endtask

  task automatic test_retire();
    logic [31:0] r;
    int unsigned n;
    next_rand(r);
    n = (r & 32'hf) + 3;
    retire_n(n);
    m_minstret = m_minstret + n;
    access_check(priv_pipe_pkg::csr_op_set, priv_arch_pkg::csr_minstret, 32'd0);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    fail_with("watchdog expired before the tests finished");
  end

  initial begin
    CLK        = 1'b0;
    rst_n      = 1'b0;
    csr_req    = 1'b0;
    req        = '0;
    exc_valid  = 1'b0;
    exc        = '0;
    mret       = 1'b0;
    retire     = 1'b0;
    int_window = 1'b0;
    ext_int    = 1'b0;
    timer_int  = 1'b0;
    rng        = 32'h6b8f;
    m_mstatus  = 32'd0;
    m_mie      = 32'd0;
    m_mcause   = 32'd0;
    m_minstret = 32'd0;
    repeat (4) @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);
    test_merge();
    test_invalid();
    test_exception();
    test_mret();
    test_interrupts();
    test_retire();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
